// File: sim.f
+incdir+include
src/cpu_ctrl_pkg.sv
src/cpu_exec_pkg.sv
src/microcode.sv
src/control_logic.sv
src/datapath.sv
src/exec_unit.sv
src/word_ram.sv
src/cpu_top.sv
bench/cpu_asserts.sv
bench/cpu_tb.sv

// File: run.sh
#!/bin/sh
# Build and run the cpu testbench with Verilator from the project root.

cd "$(dirname "$0")" || exit 1

verilator --binary --assert -j 0 --top-module cpu_tb -f sim.f -o cpu_sim
if [ $? -ne 0 ]; then
  echo "Verilator build failed."
  exit 1
fi

./obj_dir/cpu_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status."
  exit 1
fi

if grep -q "TESTBENCH PASSED" sim.log; then
  exit 0
else
  echo "Pass message not found in sim.log."
  exit 1
fi

// File: bench/cpu_tb.sv
`timescale 1ns/1ps
`include "cpu_macros.svh"

module cpu_tb;
  localparam int NROWS  = 5;
  localparam int MAXW   = 9;  // Eight program words plus the self-loop.
  localparam int CLK_NS = 8;

  logic                   clk;
  logic                   rst_n;
  logic                   booted;
  logic [`CPU_RAM_AW-1:0] boot_addr;
  logic                   boot_we;
  logic [`CPU_WORD_W-1:0] boot_wdata;
  logic [`CPU_WORD_W-1:0] boot_rdata;
  logic [4:0]             dbg_reg_addr;
  logic [`CPU_WORD_W-1:0] dbg_reg_data;

  logic [`CPU_WORD_W-1:0] prog [NROWS][MAXW];  // Program words per row.
  int                     nwords [NROWS];       // Loop word included.
  logic [4:0]             xreg [NROWS][4];      // Expected register index.
  logic [`CPU_WORD_W-1:0] xval [NROWS][4];      // Expected register value.
  int                     nxreg [NROWS];
  logic [`CPU_RAM_AW-1:0] xmem_addr [NROWS];    // Expected RAM word.
  logic [`CPU_WORD_W-1:0] xmem_val [NROWS];
  integer                 seed;
  int                     errors;

  cpu_top dut (
    .clk(clk), .rst_n(rst_n), .booted(booted), .boot_addr(boot_addr), .boot_we(boot_we),
    .boot_wdata(boot_wdata), .boot_rdata(boot_rdata), .dbg_reg_addr(dbg_reg_addr),
    .dbg_reg_data(dbg_reg_data));

  initial begin
    clk = 1'b0;
    forever #(CLK_NS / 2) clk = ~clk;
  end

  // Worst case per row, with a margin of four.
  initial begin
    #(NROWS * (9 + 14 * MAXW) * CLK_NS * 4);
    $display("Timeout: a program never reached its self-loop.");
    $display("TESTBENCH FAILED");
    $fatal(1, "Watchdog expired.");
  end

  task automatic check(input logic [31:0] got, input logic [31:0] want, input string what);
    if (got !== want) begin
      errors++;
      $display("[ERROR] %0t ns: %s: got %08h, expected %08h", $time, what, got, want);
      $display("TESTBENCH FAILED");
      $fatal(1, "Stopped at the first mismatch.");
    end
  endtask

  function automatic logic [31:0] enc_imm(input logic [5:0] op, input logic [4:0] d,
                                          input logic [4:0] s, input logic [15:0] imm);
    return {op, d, s, imm};
  endfunction

  function automatic logic [31:0] enc_reg(input logic [5:0] op, input logic [4:0] d,
                                          input logic [4:0] a, input logic [4:0] b);
    return {op, d, a, b, 11'd0};
  endfunction

  function automatic logic [31:0] sext16(input logic [15:0] x);
    return {{16{x[15]}}, x};
  endfunction

  task automatic put_word(input int row, input logic [31:0] word);
    prog[row][nwords[row]] = word;
    nwords[row]++;
  endtask

  task automatic expect_reg(input int row, input logic [4:0] r, input logic [31:0] v);
    xreg[row][nxreg[row]] = r;
    xval[row][nxreg[row]] = v;
    nxreg[row]++;
  endtask

  // Append BEQ r0,r0,-4 and expect it back from RAM by default.
  task automatic close_row(input int row);
    put_word(row, enc_imm(cpu_ctrl_pkg::OP_BEQ, 5'd0, 5'd0, 16'hFFFC));
    xmem_addr[row] = `CPU_RAM_AW'(nwords[row] - 1);
    xmem_val[row]  = prog[row][nwords[row] - 1];
  endtask

  task automatic build_table();
    logic [15:0] a, b, c;
    logic [4:0]  sh;
    logic [31:0] x, y;
    logic [9:0]  addr;
    for (int i = 0; i < NROWS; i++) begin
      nwords[i] = 0;
      nxreg[i]  = 0;
    end
    a = 16'($random(seed));  // Row 0, immediate loads.
    b = 16'($random(seed)) & 16'h7FFF;
    c = 16'($random(seed)) | 16'h8000;
    put_word(0, enc_imm(cpu_ctrl_pkg::OP_LHU, 5'd1, 5'd0, a));
    put_word(0, enc_imm(cpu_ctrl_pkg::OP_LH, 5'd2, 5'd0, b));
    put_word(0, enc_imm(cpu_ctrl_pkg::OP_LH, 5'd3, 5'd0, c));
    expect_reg(0, 5'd1, {16'h0, a});
    expect_reg(0, 5'd2, sext16(b));
    expect_reg(0, 5'd3, sext16(c));
    close_row(0);
    a  = 16'($random(seed));  // Row 1, ADDU and SLL.
    b  = 16'($random(seed));
    c  = 16'($random(seed)) | 16'h8000;
    sh = 5'($random(seed));
    put_word(1, enc_imm(cpu_ctrl_pkg::OP_LHU, 5'd1, 5'd0, a));
    put_word(1, enc_imm(cpu_ctrl_pkg::OP_ADDU, 5'd2, 5'd1, b));
    put_word(1, enc_imm(cpu_ctrl_pkg::OP_SLL, 5'd3, 5'd1, {11'd0, sh}));
    put_word(1, enc_imm(cpu_ctrl_pkg::OP_LH, 5'd4, 5'd0, c));
    put_word(1, enc_imm(cpu_ctrl_pkg::OP_ADDU, 5'd5, 5'd4, b));
    expect_reg(1, 5'd2, {16'h0, a} + {16'h0, b});
    expect_reg(1, 5'd3, {16'h0, a} << sh);
    expect_reg(1, 5'd4, sext16(c));
    expect_reg(1, 5'd5, sext16(c) + {16'h0, b});  // Wraps past 32 bits.
    close_row(1);
    x = 32'($random(seed));  // Row 2, full-width ADD3 and OR3.
    y = 32'($random(seed));
    put_word(2, enc_imm(cpu_ctrl_pkg::OP_LH, 5'd1, 5'd0, x[31:16]));
    put_word(2, enc_imm(cpu_ctrl_pkg::OP_SLL, 5'd1, 5'd1, 16'd16));
    put_word(2, enc_imm(cpu_ctrl_pkg::OP_ADDU, 5'd1, 5'd1, x[15:0]));
    put_word(2, enc_imm(cpu_ctrl_pkg::OP_LH, 5'd2, 5'd0, y[31:16]));
    put_word(2, enc_imm(cpu_ctrl_pkg::OP_SLL, 5'd2, 5'd2, 16'd16));
    put_word(2, enc_imm(cpu_ctrl_pkg::OP_ADDU, 5'd2, 5'd2, y[15:0]));
    put_word(2, enc_reg(cpu_ctrl_pkg::OP_ADD3, 5'd3, 5'd1, 5'd2));
    put_word(2, enc_reg(cpu_ctrl_pkg::OP_OR3, 5'd4, 5'd1, 5'd2));
    expect_reg(2, 5'd1, x);
    expect_reg(2, 5'd2, y);
    expect_reg(2, 5'd3, x + y);
    expect_reg(2, 5'd4, x | y);
    close_row(2);
    x    = 32'($random(seed));  // Row 3, SW then LW.
    addr = {2'b10, 6'($random(seed)), 2'b00};  // Data area above the program.
    put_word(3, enc_imm(cpu_ctrl_pkg::OP_LHU, 5'd1, 5'd0, {6'd0, addr}));
    put_word(3, enc_imm(cpu_ctrl_pkg::OP_LH, 5'd2, 5'd0, x[31:16]));
    put_word(3, enc_imm(cpu_ctrl_pkg::OP_SLL, 5'd2, 5'd2, 16'd16));
    put_word(3, enc_imm(cpu_ctrl_pkg::OP_ADDU, 5'd2, 5'd2, x[15:0]));
    put_word(3, enc_imm(cpu_ctrl_pkg::OP_SW, 5'd1, 5'd2, 16'd0));
    put_word(3, enc_imm(cpu_ctrl_pkg::OP_LW, 5'd3, 5'd1, 16'd0));
    expect_reg(3, 5'd1, {22'd0, addr});
    expect_reg(3, 5'd2, x);
    expect_reg(3, 5'd3, x);
    close_row(3);
    xmem_addr[3] = addr[9:2];
    xmem_val[3]  = x;
    a = 16'($random(seed));  // Row 4, BEQ taken and not taken.
    b = a + 16'd1;
    c = 16'($random(seed)) | 16'h0001;  // Marker, never zero.
    put_word(4, enc_imm(cpu_ctrl_pkg::OP_LHU, 5'd1, 5'd0, a));
    put_word(4, enc_imm(cpu_ctrl_pkg::OP_LHU, 5'd2, 5'd0, a));
    put_word(4, enc_imm(cpu_ctrl_pkg::OP_BEQ, 5'd1, 5'd2, 16'd4));  // Equal, skip one.
    put_word(4, enc_imm(cpu_ctrl_pkg::OP_LHU, 5'd3, 5'd0, c));
    put_word(4, enc_imm(cpu_ctrl_pkg::OP_LHU, 5'd4, 5'd0, b));
    put_word(4, enc_imm(cpu_ctrl_pkg::OP_BEQ, 5'd1, 5'd4, 16'd4));  // Differ, fall through.
    put_word(4, enc_imm(cpu_ctrl_pkg::OP_LHU, 5'd5, 5'd0, c));
    expect_reg(4, 5'd3, 32'd0);
    expect_reg(4, 5'd5, {16'h0, c});
    expect_reg(4, 5'd4, {16'h0, b});
    expect_reg(4, 5'd2, {16'h0, a});
    close_row(4);
  endtask

  task automatic run_row(input int row);
    logic [31:0] loop_pc;
    loop_pc = 32'((nwords[row] - 1) * 4);
    @(posedge clk);
    rst_n  <= 1'b0;
    booted <= 1'b0;
    repeat (4) @(posedge clk);
    rst_n <= 1'b1;
    for (int i = 0; i < nwords[row]; i++) begin
      @(posedge clk);
      boot_we    <= 1'b1;
      boot_addr  <= `CPU_RAM_AW'(i);
      boot_wdata <= prog[row][i];
    end
    @(posedge clk);
    boot_we <= 1'b0;
    for (int r = 0; r < `CPU_NREGS; r++) begin  // Still held, r31 read last.
      @(posedge clk);
      dbg_reg_addr <= 5'(r);
      @(negedge clk);
      check(dbg_reg_data, '0, $sformatf("row %0d r%0d before boot", row, r));
    end
    @(posedge clk);
    dbg_reg_addr <= 5'(`CPU_PC_REG);
    booted       <= 1'b1;
    @(negedge clk);
    while (dbg_reg_data !== loop_pc + 32'd4) @(negedge clk);  // Loop fetched.
    repeat (8) @(posedge clk);  // Dispatch plus BEQ steps up to the PC write.
    @(posedge clk);
    booted <= 1'b0;  // Freeze the core for readback.
    @(negedge clk);
    check(dbg_reg_data, loop_pc, $sformatf("row %0d PC at self-loop", row));
    for (int k = 0; k < nxreg[row]; k++) begin
      @(posedge clk);
      dbg_reg_addr <= xreg[row][k];
      @(negedge clk);
      check(dbg_reg_data, xval[row][k], $sformatf("row %0d r%0d", row, xreg[row][k]));
    end
    @(posedge clk);
    boot_addr <= xmem_addr[row];
    @(negedge clk);
    check(boot_rdata, xmem_val[row], $sformatf("row %0d RAM word %0d", row, xmem_addr[row]));
  endtask

  initial begin
    rst_n        <= 1'b0;
    booted       <= 1'b0;
    boot_addr    <= '0;
    boot_we      <= 1'b0;
    boot_wdata   <= '0;
    dbg_reg_addr <= '0;
    errors = 0;
    seed   = 32'h8c0c;
    build_table();
    for (int row = 0; row < NROWS; row++)
      run_row(row);
    if (errors == 0) begin
      $display("TESTBENCH PASSED");
      $finish;
    end else begin
      $display("TESTBENCH FAILED");
      $fatal(1, "Mismatches were found.");
    end
  end

endmodule

// File: bench/cpu_asserts.sv
`timescale 1ns/1ps
`include "cpu_macros.svh"

module cpu_asserts (
  input logic                   clk,
  input logic                   rst_n,
  input logic                   booted,
  input logic [11:0]            uaddr,         // {cond, opcode, uop count}.
  input logic                   boot_we,
  input logic [`CPU_RAM_AW-1:0] boot_addr,
  input logic [`CPU_WORD_W-1:0] boot_rdata,
  input logic [4:0]             dbg_reg_addr,
  input logic [`CPU_WORD_W-1:0] dbg_reg_data
);
  a_uop_range: assert property (@(posedge clk) disable iff (!rst_n)
      uaddr[4:0] <= 5'd16)  // Longest sequence is nine steps.
    else $error("micro-op counter went above 16");
  a_opcode_known: assert property (@(posedge clk) disable iff (!rst_n)
      uaddr[10:5] <= 6'(cpu_ctrl_pkg::OP_SLL))  // Opcodes are dense from zero.
    else $error("opcode register holds an undefined opcode");
  a_hold_unbooted: assert property (@(posedge clk) disable iff (!rst_n)
      !booted |=> $stable(uaddr[10:0]))  // Opcode and counter frozen.
    else $error("control state moved while not booted");
  a_no_reg_write: assert property (@(posedge clk) disable iff (!rst_n)
      (!booted ##1 $stable(dbg_reg_addr)) |-> $stable(dbg_reg_data))
    else $error("register changed while not booted");
  a_no_ram_write: assert property (@(posedge clk) disable iff (!rst_n)
      ((!booted && !boot_we) ##1 $stable(boot_addr)) |-> $stable(boot_rdata))
    else $error("RAM changed by the core while not booted");

endmodule

bind cpu_top cpu_asserts u_asserts (
  .clk(clk), .rst_n(rst_n), .booted(booted), .uaddr(uaddr), .boot_we(boot_we),
  .boot_addr(boot_addr), .boot_rdata(boot_rdata), .dbg_reg_addr(dbg_reg_addr),
  .dbg_reg_data(dbg_reg_data));

// File: src/cpu_top.sv
`timescale 1ns/1ps
`include "cpu_macros.svh"

module cpu_top (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   booted,
  input  logic [`CPU_RAM_AW-1:0] boot_addr,
  input  logic                   boot_we,
  input  logic [`CPU_WORD_W-1:0] boot_wdata,
  output logic [`CPU_WORD_W-1:0] boot_rdata,
  input  logic [4:0]             dbg_reg_addr,
  output logic [`CPU_WORD_W-1:0] dbg_reg_data
);
  cpu_ctrl_pkg::ctrl_word_t ctrl;
  logic [11:0]              uaddr;
  logic [4:0]               reg_idx;
  logic [`CPU_WORD_W-1:0]   bus, tmp0, tmp1, opword;
  logic [`CPU_WORD_W-1:0]   mlu_out, shift_out, mem_rdata;
  logic                     flag_zero, flag_carry, flag_neg;
  logic                     mem_we;

  assign mem_we = (ctrl.in_sel == cpu_ctrl_pkg::IN_MEM);

  microcode u_ucode (.uaddr(uaddr), .ctrl(ctrl));

  control_logic u_ctrl (
    .clk(clk), .rst_n(rst_n), .booted(booted), .ctrl(ctrl), .bus(bus), .opword(opword),
    .flag_zero(flag_zero), .flag_carry(flag_carry), .flag_neg(flag_neg),
    .uaddr(uaddr), .reg_idx(reg_idx));

  datapath u_dp (
    .clk(clk), .rst_n(rst_n), .booted(booted), .ctrl(ctrl), .reg_idx(reg_idx),
    .mlu_out(mlu_out), .shift_out(shift_out), .mem_rdata(mem_rdata),
    .dbg_reg_addr(dbg_reg_addr), .bus(bus), .tmp0(tmp0), .tmp1(tmp1), .opword(opword),
    .dbg_reg_data(dbg_reg_data));

  exec_unit u_exec (
    .tmp0(tmp0), .tmp1(tmp1), .mlu_op(cpu_exec_pkg::mlu_op_t'(ctrl.mlu_op)),
    .mlu_carry(ctrl.mlu_carry), .shift_mode(cpu_exec_pkg::shift_mode_t'(ctrl.shift_mode)),
    .mlu_out(mlu_out), .shift_out(shift_out),
    .flag_zero(flag_zero), .flag_carry(flag_carry), .flag_neg(flag_neg));

  word_ram u_ram (
    .clk(clk), .booted(booted), .we(mem_we), .addr(tmp0), .wdata(bus), .rdata(mem_rdata),
    .boot_addr(boot_addr), .boot_we(boot_we), .boot_wdata(boot_wdata),
    .boot_rdata(boot_rdata));

endmodule

// File: src/word_ram.sv
`timescale 1ns/1ps
`include "cpu_macros.svh"

module word_ram (
  input  logic                   clk,
  input  logic                   booted,
  input  logic                   we,
  input  logic [`CPU_WORD_W-1:0] addr,        // Byte address from TMP0.
  input  logic [`CPU_WORD_W-1:0] wdata,
  output logic [`CPU_WORD_W-1:0] rdata,
  input  logic [`CPU_RAM_AW-1:0] boot_addr,   // Word address.
  input  logic                   boot_we,
  input  logic [`CPU_WORD_W-1:0] boot_wdata,
  output logic [`CPU_WORD_W-1:0] boot_rdata
);
  logic [`CPU_WORD_W-1:0] mem [2**`CPU_RAM_AW];
  logic [`CPU_RAM_AW-1:0] core_idx;

  assign core_idx = addr[`CPU_RAM_AW+1:2];  // Drop byte offset.

  always_ff @(posedge clk) begin
    if (!booted && boot_we)
      mem[boot_addr] <= boot_wdata;  // Loader owns the RAM.
    else if (booted && we)
      mem[core_idx] <= wdata;
  end

  assign rdata      = mem[core_idx];
  assign boot_rdata = mem[boot_addr];

endmodule

// File: src/exec_unit.sv
`timescale 1ns/1ps
`include "cpu_macros.svh"

module exec_unit (
  input  logic [`CPU_WORD_W-1:0]  tmp0,
  input  logic [`CPU_WORD_W-1:0]  tmp1,
  input  cpu_exec_pkg::mlu_op_t   mlu_op,
  input  logic                    mlu_carry,
  input  cpu_exec_pkg::shift_mode_t shift_mode,
  output logic [`CPU_WORD_W-1:0]  mlu_out,
  output logic [`CPU_WORD_W-1:0]  shift_out,
  output logic                    flag_zero,
  output logic                    flag_carry,
  output logic                    flag_neg
);
  logic [`CPU_WORD_W:0] sum;  // Carry in the top bit.

  always_comb begin
    sum = '0;
    case (mlu_op)
      cpu_exec_pkg::MLU_ADD:  sum = {1'b0, tmp0} + {1'b0, tmp1} + mlu_carry;
      cpu_exec_pkg::MLU_SUB:  sum = {1'b0, tmp0} + {1'b0, ~tmp1} + mlu_carry;
      cpu_exec_pkg::MLU_AND:  sum[`CPU_WORD_W-1:0] = tmp0 & tmp1;
      cpu_exec_pkg::MLU_OR:   sum[`CPU_WORD_W-1:0] = tmp0 | tmp1;
      cpu_exec_pkg::MLU_ANOT: sum[`CPU_WORD_W-1:0] = tmp0 & ~tmp1;
      default: ;
    endcase
  end

  assign mlu_out    = sum[`CPU_WORD_W-1:0];
  assign flag_zero  = (mlu_out == '0);
  assign flag_carry = sum[`CPU_WORD_W];
  assign flag_neg   = mlu_out[`CPU_WORD_W-1];

  always_comb begin
    case (shift_mode)
      cpu_exec_pkg::SHIFT_LEFT:      shift_out = tmp0 << tmp1[4:0];
      cpu_exec_pkg::SHIFT_SIGNEXT16: shift_out = {{(`CPU_WORD_W-16){tmp0[15]}}, tmp0[15:0]};
      default:                       shift_out = tmp0;
    endcase
  end

endmodule

// File: src/datapath.sv
`timescale 1ns/1ps
`include "cpu_macros.svh"

module datapath (
  input  logic                     clk,
  input  logic                     rst_n,
  input  logic                     booted,
  input  cpu_ctrl_pkg::ctrl_word_t ctrl,
  input  logic [4:0]               reg_idx,
  input  logic [`CPU_WORD_W-1:0]   mlu_out,
  input  logic [`CPU_WORD_W-1:0]   shift_out,
  input  logic [`CPU_WORD_W-1:0]   mem_rdata,
  input  logic [4:0]               dbg_reg_addr,
  output logic [`CPU_WORD_W-1:0]   bus,
  output logic [`CPU_WORD_W-1:0]   tmp0,
  output logic [`CPU_WORD_W-1:0]   tmp1,
  output logic [`CPU_WORD_W-1:0]   opword,
  output logic [`CPU_WORD_W-1:0]   dbg_reg_data
);
  logic [`CPU_WORD_W-1:0] regs [`CPU_NREGS];

  // One bus source per cycle.
  always_comb begin
    case (ctrl.out_sel)
      cpu_ctrl_pkg::OUT_REG:        bus = regs[reg_idx];
      cpu_ctrl_pkg::OUT_TMP0:       bus = tmp0;
      cpu_ctrl_pkg::OUT_TMP1:       bus = tmp1;
      cpu_ctrl_pkg::OUT_MEM:        bus = mem_rdata;
      cpu_ctrl_pkg::OUT_MLU:        bus = mlu_out;
      cpu_ctrl_pkg::OUT_SHIFTER:    bus = shift_out;
      cpu_ctrl_pkg::OUT_CTRL_DATA:  bus = {{(`CPU_WORD_W-8){1'b0}}, ctrl.ctrl_data};
      cpu_ctrl_pkg::OUT_OPWORD_IMM: bus = {{(`CPU_WORD_W-16){1'b0}}, opword[15:0]};
      default:                      bus = '0;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < `CPU_NREGS; i++)
        regs[i] <= '0;
      tmp0   <= '0;
      tmp1   <= '0;
      opword <= '0;
    end else if (booted) begin
      case (ctrl.in_sel)
        cpu_ctrl_pkg::IN_REG:    regs[reg_idx] <= bus;
        cpu_ctrl_pkg::IN_TMP0:   tmp0 <= bus;
        cpu_ctrl_pkg::IN_TMP1:   tmp1 <= bus;
        cpu_ctrl_pkg::IN_OPWORD: opword <= bus;
        default: ;  // MEM and OPCODE captured elsewhere.
      endcase
    end
  end

  assign dbg_reg_data = regs[dbg_reg_addr];  // Any time, no clock.

endmodule

// File: src/control_logic.sv
`timescale 1ns/1ps
`include "cpu_macros.svh"

module control_logic (
  input  logic                       clk,
  input  logic                       rst_n,
  input  logic                       booted,
  input  cpu_ctrl_pkg::ctrl_word_t   ctrl,
  input  logic [`CPU_WORD_W-1:0]     bus,
  input  logic [`CPU_WORD_W-1:0]     opword,
  input  logic                       flag_zero,
  input  logic                       flag_carry,
  input  logic                       flag_neg,
  output logic [11:0]                uaddr,
  output logic [4:0]                 reg_idx
);
  cpu_ctrl_pkg::opcode_t opcode;    // Current instruction.
  logic [`CPU_UOP_W-1:0] uop_cnt;   // Step within it.
  logic                  cond;      // Flag seen by the next step.
  logic                  cond_next;

  always_comb begin
    case (ctrl.cond_sel)
      cpu_ctrl_pkg::COND_ZERO:  cond_next = flag_zero;
      cpu_ctrl_pkg::COND_CARRY: cond_next = flag_carry;
      cpu_ctrl_pkg::COND_NEG:   cond_next = flag_neg;
      default:                  cond_next = 1'b0;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      opcode  <= cpu_ctrl_pkg::OP_RESET;
      uop_cnt <= '0;
      cond    <= 1'b0;
    end else begin
      cond <= cond_next;
      if (booted) begin
        uop_cnt <= ctrl.misc ? '0 : uop_cnt + 1'b1;
        if (ctrl.in_sel == cpu_ctrl_pkg::IN_OPCODE)
          opcode <= (ctrl.opcode_sel == cpu_ctrl_pkg::OPC_FROM_BUS) ?
                    cpu_ctrl_pkg::opcode_t'(bus[5:0]) :
                    cpu_ctrl_pkg::opcode_t'(opword[31:26]);
      end
    end
  end

  assign uaddr = {cond, opcode, uop_cnt};

  always_comb begin
    case (ctrl.reg_sel)
      cpu_ctrl_pkg::REG_SEL_OPWORD0: reg_idx = opword[25:21];  // rD.
      cpu_ctrl_pkg::REG_SEL_OPWORD1: reg_idx = opword[20:16];  // rS / rA.
      cpu_ctrl_pkg::REG_SEL_OPWORD2: reg_idx = opword[15:11];  // rB.
      default:                       reg_idx = ctrl.ctrl_data[4:0];
    endcase
  end

endmodule

// File: src/microcode.sv
`timescale 1ns/1ps
`include "cpu_macros.svh"

module microcode (
  input  logic [11:0]              uaddr,
  output cpu_ctrl_pkg::ctrl_word_t ctrl
);
  logic                  cond;  // Latched condition.
  cpu_ctrl_pkg::opcode_t opcode;
  logic [4:0]            uop;

  assign cond   = uaddr[11];
  assign opcode = cpu_ctrl_pkg::opcode_t'(uaddr[10:5]);
  assign uop    = uaddr[4:0];

  // Load FETCH through the bus and restart the counter.
  `define GO_FETCH begin \
      ctrl.ctrl_data  = {2'b00, cpu_ctrl_pkg::OP_FETCH}; \
      ctrl.out_sel    = cpu_ctrl_pkg::OUT_CTRL_DATA; \
      ctrl.in_sel     = cpu_ctrl_pkg::IN_OPCODE; \
      ctrl.misc       = 1'b1; \
      ctrl.opcode_sel = cpu_ctrl_pkg::OPC_FROM_BUS; \
    end

  always_comb begin
    ctrl = '0;
    case (opcode)
      cpu_ctrl_pkg::OP_RESET: begin
        case (uop)
          0: begin  // PC = 0, bus is zero for none.
            ctrl.ctrl_data = 8'(`CPU_PC_REG);
            ctrl.reg_sel   = cpu_ctrl_pkg::REG_SEL_CTRL;
            ctrl.in_sel    = cpu_ctrl_pkg::IN_REG;
          end
          default: `GO_FETCH
        endcase
      end
      cpu_ctrl_pkg::OP_FETCH: begin
        case (uop)
          0: begin
            ctrl.ctrl_data = 8'(`CPU_PC_REG);
            ctrl.reg_sel   = cpu_ctrl_pkg::REG_SEL_CTRL;
            ctrl.out_sel   = cpu_ctrl_pkg::OUT_REG;  // PC to TMP0 as address.
            ctrl.in_sel    = cpu_ctrl_pkg::IN_TMP0;
          end
          1: begin
            ctrl.out_sel = cpu_ctrl_pkg::OUT_MEM;  // Instruction word.
            ctrl.in_sel  = cpu_ctrl_pkg::IN_OPWORD;
          end
          2: begin
            ctrl.ctrl_data = 8'd4;  // PC step.
            ctrl.out_sel   = cpu_ctrl_pkg::OUT_CTRL_DATA;
            ctrl.in_sel    = cpu_ctrl_pkg::IN_TMP1;
          end
          3: begin
            ctrl.ctrl_data = 8'(`CPU_PC_REG);
            ctrl.reg_sel   = cpu_ctrl_pkg::REG_SEL_CTRL;
            ctrl.out_sel   = cpu_ctrl_pkg::OUT_MLU;  // PC + 4.
            ctrl.in_sel    = cpu_ctrl_pkg::IN_REG;
            ctrl.mlu_op    = cpu_exec_pkg::MLU_ADD;
          end
          default: begin
            ctrl.in_sel     = cpu_ctrl_pkg::IN_OPCODE;  // Dispatch.
            ctrl.misc       = 1'b1;
            ctrl.opcode_sel = cpu_ctrl_pkg::OPC_FROM_OPWORD;
          end
        endcase
      end
      cpu_ctrl_pkg::OP_LHU: begin
        case (uop)
          0: begin
            ctrl.reg_sel = cpu_ctrl_pkg::REG_SEL_OPWORD0;
            ctrl.out_sel = cpu_ctrl_pkg::OUT_OPWORD_IMM;
            ctrl.in_sel  = cpu_ctrl_pkg::IN_REG;
          end
          default: `GO_FETCH
        endcase
      end
      cpu_ctrl_pkg::OP_LH: begin
        case (uop)
          0: begin
            ctrl.out_sel = cpu_ctrl_pkg::OUT_OPWORD_IMM;
            ctrl.in_sel  = cpu_ctrl_pkg::IN_TMP0;
          end
          1: begin
            ctrl.reg_sel    = cpu_ctrl_pkg::REG_SEL_OPWORD0;
            ctrl.out_sel    = cpu_ctrl_pkg::OUT_SHIFTER;  // Sign-extended imm.
            ctrl.in_sel     = cpu_ctrl_pkg::IN_REG;
            ctrl.shift_mode = cpu_exec_pkg::SHIFT_SIGNEXT16;
          end
          default: `GO_FETCH
        endcase
      end
      cpu_ctrl_pkg::OP_ADDU, cpu_ctrl_pkg::OP_SLL,
      cpu_ctrl_pkg::OP_ADD3, cpu_ctrl_pkg::OP_OR3: begin
        case (uop)
          0: begin
            ctrl.reg_sel = cpu_ctrl_pkg::REG_SEL_OPWORD1;
            ctrl.out_sel = cpu_ctrl_pkg::OUT_REG;
            ctrl.in_sel  = cpu_ctrl_pkg::IN_TMP0;
          end
          1: begin
            ctrl.reg_sel = cpu_ctrl_pkg::REG_SEL_OPWORD2;
            ctrl.in_sel  = cpu_ctrl_pkg::IN_TMP1;
            if (opcode == cpu_ctrl_pkg::OP_ADD3 || opcode == cpu_ctrl_pkg::OP_OR3)
              ctrl.out_sel = cpu_ctrl_pkg::OUT_REG;  // rB.
            else
              ctrl.out_sel = cpu_ctrl_pkg::OUT_OPWORD_IMM;
          end
          2: begin
            ctrl.reg_sel = cpu_ctrl_pkg::REG_SEL_OPWORD0;
            ctrl.in_sel  = cpu_ctrl_pkg::IN_REG;
            ctrl.out_sel = cpu_ctrl_pkg::OUT_MLU;
            if (opcode == cpu_ctrl_pkg::OP_OR3)
              ctrl.mlu_op = cpu_exec_pkg::MLU_OR;
            if (opcode == cpu_ctrl_pkg::OP_SLL) begin
              ctrl.out_sel    = cpu_ctrl_pkg::OUT_SHIFTER;
              ctrl.shift_mode = cpu_exec_pkg::SHIFT_LEFT;
            end
          end
          default: `GO_FETCH
        endcase
      end
      cpu_ctrl_pkg::OP_SW, cpu_ctrl_pkg::OP_LW: begin
        case (uop)
          0: begin  // Address register into TMP0.
            ctrl.reg_sel = (opcode == cpu_ctrl_pkg::OP_SW) ?
                           cpu_ctrl_pkg::REG_SEL_OPWORD0 : cpu_ctrl_pkg::REG_SEL_OPWORD1;
            ctrl.out_sel = cpu_ctrl_pkg::OUT_REG;
            ctrl.in_sel  = cpu_ctrl_pkg::IN_TMP0;
          end
          1: begin
            if (opcode == cpu_ctrl_pkg::OP_SW) begin
              ctrl.reg_sel = cpu_ctrl_pkg::REG_SEL_OPWORD1;  // rS to memory.
              ctrl.out_sel = cpu_ctrl_pkg::OUT_REG;
              ctrl.in_sel  = cpu_ctrl_pkg::IN_MEM;
            end else begin
              ctrl.reg_sel = cpu_ctrl_pkg::REG_SEL_OPWORD0;  // Memory to rD.
              ctrl.out_sel = cpu_ctrl_pkg::OUT_MEM;
              ctrl.in_sel  = cpu_ctrl_pkg::IN_REG;
            end
          end
          default: `GO_FETCH
        endcase
      end
      cpu_ctrl_pkg::OP_BEQ: begin
        case (uop)
          0: begin
            ctrl.reg_sel = cpu_ctrl_pkg::REG_SEL_OPWORD0;
            ctrl.out_sel = cpu_ctrl_pkg::OUT_REG;
            ctrl.in_sel  = cpu_ctrl_pkg::IN_TMP0;
          end
          1: begin
            ctrl.reg_sel = cpu_ctrl_pkg::REG_SEL_OPWORD1;
            ctrl.out_sel = cpu_ctrl_pkg::OUT_REG;
            ctrl.in_sel  = cpu_ctrl_pkg::IN_TMP1;
          end
          2: begin  // rA - rB, zero flag seen next step.
            ctrl.mlu_op    = cpu_exec_pkg::MLU_SUB;
            ctrl.mlu_carry = 1'b1;
            ctrl.cond_sel  = cpu_ctrl_pkg::COND_ZERO;
          end
          3: begin
            if (cond) begin
              ctrl.out_sel = cpu_ctrl_pkg::OUT_OPWORD_IMM;  // Offset for sign extend.
              ctrl.in_sel  = cpu_ctrl_pkg::IN_TMP0;
            end else begin
              `GO_FETCH  // Not equal, skip.
            end
          end
          4: ctrl.in_sel = cpu_ctrl_pkg::IN_TMP1;  // TMP1 = 0.
          5: begin
            ctrl.out_sel    = cpu_ctrl_pkg::OUT_SHIFTER;
            ctrl.in_sel     = cpu_ctrl_pkg::IN_TMP1;
            ctrl.shift_mode = cpu_exec_pkg::SHIFT_SIGNEXT16;
          end
          6: begin
            ctrl.ctrl_data = 8'(`CPU_PC_REG);
            ctrl.reg_sel   = cpu_ctrl_pkg::REG_SEL_CTRL;
            ctrl.out_sel   = cpu_ctrl_pkg::OUT_REG;
            ctrl.in_sel    = cpu_ctrl_pkg::IN_TMP0;
          end
          7: begin  // PC += offset.
            ctrl.ctrl_data = 8'(`CPU_PC_REG);
            ctrl.reg_sel   = cpu_ctrl_pkg::REG_SEL_CTRL;
            ctrl.out_sel   = cpu_ctrl_pkg::OUT_MLU;
            ctrl.in_sel    = cpu_ctrl_pkg::IN_REG;
          end
          default: `GO_FETCH
        endcase
      end
      default: `GO_FETCH
    endcase
  end

  `undef GO_FETCH

endmodule

// File: src/cpu_exec_pkg.sv
package cpu_exec_pkg;

  typedef enum logic [2:0] {
    MLU_ADD  = 3'd0,  // A + B + cin.
    MLU_SUB  = 3'd1,  // A + ~B + cin.
    MLU_AND  = 3'd2,
    MLU_OR   = 3'd3,
    MLU_ANOT = 3'd4   // A & ~B.
  } mlu_op_t;

  typedef enum logic [1:0] {
    SHIFT_NONE      = 2'd0,  // Pass TMP0.
    SHIFT_LEFT      = 2'd1,
    SHIFT_SIGNEXT16 = 2'd2
  } shift_mode_t;

endpackage

// File: src/cpu_ctrl_pkg.sv
package cpu_ctrl_pkg;

  typedef enum logic [5:0] {
    OP_RESET = 6'd0,  // Clear PC, then fetch.
    OP_FETCH = 6'd1,  // Load opword at PC, bump PC.
    OP_LHU   = 6'd2,  // rD = zeroext(I).
    OP_ADDU  = 6'd3,  // rD = rS + zeroext(I).
    OP_ADD3  = 6'd4,  // rD = rA + rB.
    OP_SW    = 6'd5,  // [rD] = rS.
    OP_OR3   = 6'd6,  // rD = rA | rB.
    OP_LH    = 6'd7,  // rD = signext(I).
    OP_BEQ   = 6'd8,  // If rA == rB then PC += signext(I).
    OP_LW    = 6'd9,  // rD = [rS].
    OP_SLL   = 6'd10  // rD = rS << I[4:0].
  } opcode_t;

  typedef enum logic [3:0] {
    OUT_NONE       = 4'd0,  // Bus reads zero.
    OUT_REG        = 4'd1,
    OUT_TMP0       = 4'd2,
    OUT_TMP1       = 4'd3,
    OUT_MEM        = 4'd4,
    OUT_MLU        = 4'd5,
    OUT_SHIFTER    = 4'd6,
    OUT_CTRL_DATA  = 4'd8,  // Zero-extended ctrl_data.
    OUT_OPWORD_IMM = 4'd9   // Zero-extended opword[15:0].
  } out_sel_t;

  typedef enum logic [2:0] {
    IN_NONE, IN_REG, IN_TMP0, IN_TMP1, IN_MEM, IN_OPWORD, IN_OPCODE
  } in_sel_t;

  typedef enum logic [1:0] {
    REG_SEL_OPWORD0, REG_SEL_OPWORD1, REG_SEL_OPWORD2, REG_SEL_CTRL
  } reg_sel_t;

  typedef enum logic [1:0] {COND_ZERO, COND_CARRY, COND_NEG, COND_NONE} cond_sel_t;

  localparam logic OPC_FROM_OPWORD = 1'b0;
  localparam logic OPC_FROM_BUS    = 1'b1;

  typedef struct packed {
    logic [3:0] rsvd;         // Bits 31:28, always zero.
    cond_sel_t  cond_sel;     // Bits 27:26.
    logic       opcode_sel;   // Bit 25.
    logic       shift_arith;  // Bit 24, no arithmetic shift in this core.
    logic [1:0] shift_mode;   // Bits 23:22, a cpu_exec_pkg::shift_mode_t.
    logic       mlu_carry;    // Bit 21.
    logic [2:0] mlu_op;       // Bits 20:18, a cpu_exec_pkg::mlu_op_t.
    logic       misc;         // Bit 17, restarts the micro-op counter.
    in_sel_t    in_sel;       // Bits 16:14.
    out_sel_t   out_sel;      // Bits 13:10.
    reg_sel_t   reg_sel;      // Bits 9:8.
    logic [7:0] ctrl_data;    // Bits 7:0.
  } ctrl_word_t;

endpackage

// File: include/cpu_macros.svh
`ifndef CPU_MACROS_SVH
`define CPU_MACROS_SVH

// Data word width in bits.
`define CPU_WORD_W 32
// RAM word-address bits, 256 words.
`define CPU_RAM_AW 8
// Register file entries, r31 doubles as the PC.
`define CPU_NREGS 32
// Micro-op counter width.
`define CPU_UOP_W 5
`define CPU_PC_REG 31

`endif
